// File: compile.f
+incdir+.
hazardPkg.sv
hazardStageIf.sv
instrDecodeInfo.sv
loadUseCheck.sv
branchOperandCheck.sv
hazardDetection.sv
pipeTracker.sv
hazardCore.sv
hazardCore_chk.sv
tb_hazardCore.sv

// File: Makefile
TOP = tb_hazardCore
OBJ = obj_dir

.PHONY: all compile run clean

all: run

# build the testbench with the bound assertion module and timing support
compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# a failing check or assertion makes the binary exit with a nonzero status
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// File: tb_hazardCore.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_hazardCore;
	import hazardPkg::*;

	localparam int RESET_CYCLES = 3;
	localparam int TAIL_LEN = 40;

	// one table row is one fetch cycle together with what the DUT must answer
	typedef struct packed {
		instrT fetch;
		logic branch;
		logic expPc;
		logic expFlush;
		logic expMiss;
		instrT expIdex;
	} stepT;

	logic clk;
	logic rstN;
	instrT fetchInstr;
	logic takeBranch;
	logic pcEnable;
	logic flushIfid;
	logic mispredict;
	instrT ifidInstr;
	instrT idexInstr;
	instrT exmemInstr;

	stepT steps[$];
	instrT tailWords[$];
	logic [31:0] rngState = 32'h0241_cbb7;
	int cycleCount = 0;
	int cycleLimit = 0;

	hazardCore dut (
		.clk       (clk),
		.rstN      (rstN),
		.fetchInstr(fetchInstr),
		.takeBranch(takeBranch),
		.pcEnable  (pcEnable),
		.flushIfid (flushIfid),
		.mispredict(mispredict),
		.ifidInstr (ifidInstr),
		.idexInstr (idexInstr),
		.exmemInstr(exmemInstr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// the run must be over well before this many edges
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("sim failed");
			$fatal(1, "timeout, the run did not finish within %0d cycles", cycleLimit);
		end
	end

	// instruction encoders, field order as in the RV32I base formats
	function automatic instrT encodeR(logic [6:0] funct7, regIdxT rs2, regIdxT rs1,
			logic [2:0] funct3, regIdxT rd, opcodeT opc);
		return {funct7, rs2, rs1, funct3, rd, opc};
	endfunction

	function automatic instrT encodeI(logic [11:0] imm, regIdxT rs1, logic [2:0] funct3,
			regIdxT rd, opcodeT opc);
		return {imm, rs1, funct3, rd, opc};
	endfunction

	// beq with a fixed forward offset of 8 bytes
	function automatic instrT encodeBeq(regIdxT rs1, regIdxT rs2);
		return {7'd0, rs2, rs1, 3'b000, 5'b01000, `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] nextRandom(logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkInstr(string name, instrT actual, instrT expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic checkCtl(string name, logic actual, logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic addStep(instrT f, logic br, logic pc, logic fl, logic mis, instrT idex);
		stepT s;
		s = '{fetch: f, branch: br, expPc: pc, expFlush: fl, expMiss: mis, expIdex: idex};
		steps.push_back(s);
	endtask

	// idexInstr in a row is the word that entered IF/ID two rows earlier,
	// or a nop when that row was flushed
	task automatic buildTable();
		instrT nop;
		instrT ld5;
		instrT add5;
		instrT add6;
		instrT beq6;
		instrT ld7;
		instrT beq7;
		instrT ld0;
		instrT add0;
		instrT ax0;
		instrT beq0;
		nop = `NOP_INSTR;
		ld5 = encodeI(12'd0, 5'd1, 3'b010, 5'd5, `OPC_LOAD);
		add5 = encodeR(7'd0, 5'd2, 5'd5, 3'b000, 5'd8, `OPC_OP);
		add6 = encodeR(7'd0, 5'd2, 5'd1, 3'b000, 5'd6, `OPC_OP);
		beq6 = encodeBeq(5'd6, 5'd3);
		ld7 = encodeI(12'd4, 5'd1, 3'b010, 5'd7, `OPC_LOAD);
		// x7 sits in the second operand so the rs2 compares get exercised
		beq7 = encodeBeq(5'd4, 5'd7);
		ld0 = encodeI(12'd8, 5'd1, 3'b010, 5'd0, `OPC_LOAD);
		add0 = encodeR(7'd0, 5'd0, 5'd0, 3'b000, 5'd8, `OPC_OP);
		// reads x8 straight after add0 wrote it, an ALU result forwards without a stall
		ax0 = encodeR(7'd0, 5'd2, 5'd8, 3'b000, 5'd0, `OPC_OP);
		beq0 = encodeBeq(5'd0, 5'd0);
		// lw x5 then add reading x5, one bubble and the bubble reaches ID/EX
		addStep(ld5, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(add5, 1'b0, 1'b0, 1'b1, 1'b0, nop);
		addStep(add5, 1'b0, 1'b1, 1'b0, 1'b0, ld5);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, add5);
		// add writing x6 then beq on x6, an ALU result in EX no longer blocks
		addStep(add6, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(beq6, 1'b0, 1'b0, 1'b1, 1'b0, nop);
		addStep(beq6, 1'b0, 1'b1, 1'b0, 1'b0, add6);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, beq6);
		// lw x7 then beq on x7 stalls in decode and again with the load in EX
		addStep(ld7, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(beq7, 1'b0, 1'b0, 1'b1, 1'b0, nop);
		addStep(beq7, 1'b0, 1'b0, 1'b1, 1'b0, ld7);
		addStep(beq7, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, beq7);
		// ecall freezes the PC but is not squashed
		addStep(`ECALL_INSTR, 1'b0, 1'b0, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, `ECALL_INSTR);
		// taken branch on top of a load-use stall
		addStep(ld5, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(add5, 1'b1, 1'b1, 1'b1, 1'b1, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, ld5);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		// taken branch with no hazard at all still squashes the fetched word
		addStep(add6, 1'b1, 1'b1, 1'b1, 1'b1, nop);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		// x0 as destination is never a producer
		addStep(ld0, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(add0, 1'b0, 1'b1, 1'b0, 1'b0, nop);
		addStep(ax0, 1'b0, 1'b1, 1'b0, 1'b0, ld0);
		addStep(beq0, 1'b0, 1'b1, 1'b0, 1'b0, add0);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, ax0);
		addStep(nop, 1'b0, 1'b1, 1'b0, 1'b0, beq0);
	endtask

	// drive on the rising edge, check in the second half of the cycle
	task automatic runTable();
		stepT s;
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			@(posedge clk);
			fetchInstr <= s.fetch;
			takeBranch <= s.branch;
			@(negedge clk);
			checkCtl($sformatf("pcEnable step %0d", i), pcEnable, s.expPc);
			checkCtl($sformatf("flushIfid step %0d", i), flushIfid, s.expFlush);
			checkCtl($sformatf("mispredict step %0d", i), mispredict, s.expMiss);
			checkInstr($sformatf("idexInstr step %0d", i), idexInstr, s.expIdex);
		end
	endtask

	// R-type words reading x0..x15 and writing x16..x31, so no word feeds another
	task automatic runRandomTail();
		instrT word;
		for (int t = 0; t < TAIL_LEN; t++) begin
			rngState = nextRandom(rngState);
			word = encodeR(7'd0, {1'b0, rngState[11:8]}, {1'b0, rngState[3:0]},
				rngState[14:12], {1'b1, rngState[7:4]}, `OPC_OP);
			@(posedge clk);
			fetchInstr <= word;
			takeBranch <= 1'b0;
			tailWords.push_back(word);
			@(negedge clk);
			checkCtl($sformatf("pcEnable tail %0d", t), pcEnable, 1'b1);
			checkCtl($sformatf("flushIfid tail %0d", t), flushIfid, 1'b0);
			checkCtl($sformatf("mispredict tail %0d", t), mispredict, 1'b0);
			// each register holds the word of the cycle before it
			if (t >= 1)
				checkInstr($sformatf("ifidInstr tail %0d", t), ifidInstr, tailWords[t - 1]);
			if (t >= 2)
				checkInstr($sformatf("idexInstr tail %0d", t), idexInstr, tailWords[t - 2]);
			if (t >= 3)
				checkInstr($sformatf("exmemInstr tail %0d", t), exmemInstr, tailWords[t - 3]);
		end
	endtask

	initial begin
		rstN <= 1'b0;
		fetchInstr <= `NOP_INSTR;
		takeBranch <= 1'b0;
		buildTable();
		cycleLimit = RESET_CYCLES + steps.size() + TAIL_LEN + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		runTable();
		runRandomTail();
		$display("sim passed");
		$finish;
	end

endmodule

// File: hazardCore_chk.sv
`timescale 1ns/1ps

// control rules of the hazard block, watched from outside the design
// everything is sampled on the rising edge, once the level inputs have settled
module hazardCore_chk (
	input logic clk,
	input logic rstN,
	input logic takeBranch,
	input logic pcEnable,
	input logic flushIfid,
	input logic mispredict
);

	// with not-taken prediction every taken branch is a miss and nothing else is
	mispredictMatchesBranch: assert property (@(posedge clk) disable iff (!rstN)
		mispredict == takeBranch)
		else $error("mispredict does not follow takeBranch");

	// a redirect must load the new PC and drop the wrong-path word
	takenBranchRedirects: assert property (@(posedge clk) disable iff (!rstN)
		takeBranch |-> (pcEnable && flushIfid))
		else $error("taken branch without PC update and IF/ID flush");

	// a flush without a taken branch is a stall, so the PC has to hold
	stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
		(flushIfid && !takeBranch) |-> !pcEnable)
		else $error("stall flushed IF/ID but let the PC advance");

endmodule

bind hazardCore hazardCore_chk uChk (
	.clk       (clk),
	.rstN      (rstN),
	.takeBranch(takeBranch),
	.pcEnable  (pcEnable),
	.flushIfid (flushIfid),
	.mispredict(mispredict)
);

// File: hazardCore.sv
`timescale 1ns/1ps
`default_nettype none

// top of the hazard control block
// decodes the fetched word and the two tracked slots behind it, then
// hands the three decoded views to the hazard logic
module hazardCore (
	input logic clk,
	input logic rstN,
	input hazardPkg::instrT fetchInstr,
	input logic takeBranch,
	output logic pcEnable,
	output logic flushIfid,
	output logic mispredict,
	output hazardPkg::instrT ifidInstr,
	output hazardPkg::instrT idexInstr,
	output hazardPkg::instrT exmemInstr
);

	// decoded view of the word in fetch, in decode and in execute
	hazardStageIf fetchSlot ();
	hazardStageIf decodeSlot ();
	hazardStageIf execSlot ();

	pipeTracker uTracker (
		.clk       (clk),
		.rstN      (rstN),
		.fetchInstr(fetchInstr),
		.flushIfid (flushIfid),
		.ifidInstr (ifidInstr),
		.idexInstr (idexInstr),
		.exmemInstr(exmemInstr)
	);

	instrDecodeInfo uFetchDecode (
		.instr(fetchInstr),
		.slot (fetchSlot)
	);

	// the IF/ID word is the one being decoded this cycle
	instrDecodeInfo uDecodeDecode (
		.instr(ifidInstr),
		.slot (decodeSlot)
	);

	// and the ID/EX word is the one in execute
	instrDecodeInfo uExecDecode (
		.instr(idexInstr),
		.slot (execSlot)
	);

	hazardDetection uHazard (
		.fetchSlot (fetchSlot),
		.decodeSlot(decodeSlot),
		.execSlot  (execSlot),
		.takeBranch(takeBranch),
		.pcEnable  (pcEnable),
		.flushIfid (flushIfid),
		.mispredict(mispredict)
	);

endmodule

`default_nettype wire

// File: pipeTracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

// stands in for the datapath and carries only the instruction words
// IF/ID, ID/EX and EX/MEM are tracked, which is as deep as the hazard checks look
module pipeTracker (
	input logic clk,
	input logic rstN,
	input hazardPkg::instrT fetchInstr,
	input logic flushIfid,
	output hazardPkg::instrT ifidInstr,
	output hazardPkg::instrT idexInstr,
	output hazardPkg::instrT exmemInstr
);
	import hazardPkg::*;

	// word that IF/ID will take at the next edge
	instrT nextIfid;

	// a flushed slot becomes a bubble, so the checks further down see a nop
	assign nextIfid = flushIfid ? `NOP_INSTR : fetchInstr;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			// all nops after reset, so no slot looks like a producer
			ifidInstr <= `NOP_INSTR;
			idexInstr <= `NOP_INSTR;
			exmemInstr <= `NOP_INSTR;
		end else begin
			ifidInstr <= nextIfid;
			// later registers never flush or stall in this scheme
			idexInstr <= ifidInstr;
			exmemInstr <= idexInstr;
		end
	end

endmodule

`default_nettype wire

// File: hazardDetection.sv
`timescale 1ns/1ps
`default_nettype none

// combines the RAW checks into the PC enable, IF/ID flush and mispredict flags
// the pipeline predicts not taken, so any taken branch was a miss
module hazardDetection (
	hazardStageIf.consumer fetchSlot,
	hazardStageIf.consumer decodeSlot,
	hazardStageIf.consumer execSlot,
	input logic takeBranch,
	output logic pcEnable,
	output logic flushIfid,
	output logic mispredict
);

	logic stallLoadUse;
	logic stallAluToBranch;
	logic stallLoadToBranch;
	logic stall;

	loadUseCheck uLoadUse (
		.fetchSlot (fetchSlot),
		.decodeSlot(decodeSlot),
		.stall     (stallLoadUse)
	);

	// any writer sitting in decode while a branch is fetched
	branchOperandCheck #(
		.loadOnly(1'b0)
	) uAluToBranch (
		.fetchSlot(fetchSlot),
		.laterSlot(decodeSlot),
		.stall    (stallAluToBranch)
	);

	// a load already in execute still has no data for a branch in decode
	branchOperandCheck #(
		.loadOnly(1'b1)
	) uLoadToBranch (
		.fetchSlot(fetchSlot),
		.laterSlot(execSlot),
		.stall    (stallLoadToBranch)
	);

	assign stall = stallLoadUse | stallAluToBranch | stallLoadToBranch;

	// a taken branch wins over everything, the fetched word is on the wrong path anyway
	// ecall only freezes the PC and lets the word itself go on down
	assign pcEnable = takeBranch | ~(stall | fetchSlot.isEcall);

	// squash the fetched word both on a stall and on a redirect
	assign flushIfid = takeBranch | stall;

	assign mispredict = takeBranch;

endmodule

`default_nettype wire

// File: branchOperandCheck.sv
`timescale 1ns/1ps
`default_nettype none

// branch in fetch reading a register a later slot has not written back yet
// branches compare in decode, so their operands must be ready one stage earlier
// than an ALU operand would be
module branchOperandCheck #(
	// when set the later slot only counts if it is a load
	parameter bit loadOnly = 1'b0
) (
	hazardStageIf.consumer fetchSlot,
	hazardStageIf.consumer laterSlot,
	output logic stall
);

	logic producerHit;
	logic rs1Match;
	logic rs2Match;

	// one stage ahead any writer blocks the branch
	// two stages ahead only a load is still outstanding, an ALU result forwards
	generate
		if (loadOnly) begin : gLoad
			assign producerHit = laterSlot.regWrite & laterSlot.memRead;
		end else begin : gAny
			assign producerHit = laterSlot.regWrite;
		end
	endgenerate

	assign rs1Match = fetchSlot.usesRs1 & (fetchSlot.rs1 == laterSlot.rd);
	assign rs2Match = fetchSlot.usesRs2 & (fetchSlot.rs2 == laterSlot.rd);

	// jalr counts as a branch here too since it also resolves in decode
	assign stall = fetchSlot.isBranch & producerHit & (rs1Match | rs2Match);

endmodule

`default_nettype wire

// File: loadUseCheck.sv
`timescale 1ns/1ps
`default_nettype none

// load in decode whose result the fetched instruction needs
// the loaded value arrives too late for forwarding, so fetch has to wait a cycle
module loadUseCheck (
	hazardStageIf.consumer fetchSlot,
	hazardStageIf.consumer decodeSlot,
	output logic stall
);

	logic isLoadProducer;
	logic rs1Match;
	logic rs2Match;

	// regWrite already excludes rd == x0
	assign isLoadProducer = decodeSlot.memRead & decodeSlot.regWrite;

	// only compare against sources the fetched opcode really reads
	assign rs1Match = fetchSlot.usesRs1 & (fetchSlot.rs1 == decodeSlot.rd);
	assign rs2Match = fetchSlot.usesRs2 & (fetchSlot.rs2 == decodeSlot.rd);

	assign stall = isLoadProducer & (rs1Match | rs2Match);

endmodule

`default_nettype wire

// File: instrDecodeInfo.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

// pulls the register indices and hazard flags out of one instruction word
// purely combinational, one instance per tracked slot
module instrDecodeInfo (
	input hazardPkg::instrT instr,
	hazardStageIf.producer slot
);
	import hazardPkg::*;

	opcodeT opcode;
	regIdxT rdField;

	// set when the opcode has a destination, before the x0 mask
	logic writesRd;

	assign opcode = instr[6:0];
	assign rdField = instr[11:7];

	// the index fields are passed on as is; the uses flags say whether they count
	assign slot.rs1 = instr[19:15];
	assign slot.rs2 = instr[24:20];
	assign slot.rd = rdField;

	always_comb begin
		slot.usesRs1 = 1'b0;
		slot.usesRs2 = 1'b0;
		slot.memRead = 1'b0;
		slot.isBranch = 1'b0;
		writesRd = 1'b0;
		case (opcode)
			`OPC_OP: begin
				slot.usesRs1 = 1'b1;
				slot.usesRs2 = 1'b1;
				writesRd = 1'b1;
			end
			`OPC_OPIMM: begin
				slot.usesRs1 = 1'b1;
				writesRd = 1'b1;
			end
			`OPC_LOAD: begin
				slot.usesRs1 = 1'b1;
				slot.memRead = 1'b1;
				writesRd = 1'b1;
			end
			`OPC_STORE: begin
				slot.usesRs1 = 1'b1;
				slot.usesRs2 = 1'b1;
			end
			`OPC_BRANCH: begin
				slot.usesRs1 = 1'b1;
				slot.usesRs2 = 1'b1;
				slot.isBranch = 1'b1;
			end
			// jalr resolves in decode like a branch, so it needs rs1 early
			`OPC_JALR: begin
				slot.usesRs1 = 1'b1;
				slot.isBranch = 1'b1;
				writesRd = 1'b1;
			end
			`OPC_JAL, `OPC_LUI, `OPC_AUIPC: begin
				writesRd = 1'b1;
			end
			// csr traffic is not tracked; ecall is caught by the exact match below
			`OPC_SYSTEM: begin
				writesRd = 1'b0;
			end
			default: begin
				writesRd = 1'b0;
			end
		endcase
	end

	// a write to x0 is discarded by the register file, so it is no producer
	assign slot.regWrite = writesRd & (rdField != 5'd0);

	assign slot.isEcall = (instr == `ECALL_INSTR);

endmodule

`default_nettype wire

// File: hazardStageIf.sv
`timescale 1ns/1ps
`default_nettype none

// decoded hazard view of a single pipeline slot
// the decoder fills it in and the checkers only ever read it
interface hazardStageIf;
	import hazardPkg::*;

	// register fields straight out of the instruction word
	regIdxT rs1;
	regIdxT rs2;
	regIdxT rd;

	// flags telling which of the fields above are real for this opcode
	logic usesRs1;
	logic usesRs2;

	// regWrite is already masked for rd == x0
	logic regWrite;
	logic memRead;
	logic isBranch;
	logic isEcall;

	// driven by instrDecodeInfo
	modport producer (
		output rs1, rs2, rd, usesRs1, usesRs2, regWrite, memRead, isBranch, isEcall
	);

	// the load-use, branch-operand and top hazard logic all sit on this side
	modport consumer (
		input rs1, rs2, rd, usesRs1, usesRs2, regWrite, memRead, isBranch, isEcall
	);

endinterface

`default_nettype wire

// File: hazardPkg.sv
// shared vector types for the hazard control block
// only widths with a meaning of their own get a name here
package hazardPkg;

	// one full RV32I instruction word as it leaves the fetch stage
	typedef logic [31:0] instrT;

	// architectural register index, x0 through x31
	typedef logic [4:0] regIdxT;

	// major opcode field taken from bits [6:0] of an instruction
	typedef logic [6:0] opcodeT;

endpackage

// File: rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// canonical nop is addi x0, x0, 0
// it writes x0 only, so it can never be the producer of a hazard
`define NOP_INSTR 32'h0000_0013

// ecall is the one system word the hazard logic treats specially
`define ECALL_INSTR 32'h0000_0073

// major opcodes of RV32I, bits [6:0] of the instruction word
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111

// register-register and register-immediate ALU groups
`define OPC_OP 7'b0110011
`define OPC_OPIMM 7'b0010011

// upper immediate forms have no source register at all
`define OPC_LUI 7'b0110111
`define OPC_AUIPC 7'b0010111

// system group holds ecall, ebreak and the csr instructions
`define OPC_SYSTEM 7'b1110011

`endif
